/* logic/core_pkg.sv */
/*
 * Shared types for the integer execution core.
 * Register zero always reads zero. Immediates are sign-extended to 32 bits when used.
 */
package core_pkg;

    //////////////////////////////
    // Widths
    localparam int NUM_REGS = 32;

    // Register value and operand
    typedef logic [31:0] data_t;

    // Register number, 0 to NUM_REGS-1
    typedef logic [4:0] reg_addr_t;

    // Immediate, sign-extended on use
    typedef logic [15:0] imm_t;

    //////////////////////////////
    // Operations
    //   SLT   signed compare, result is 1 or 0
    //   ADDI  rs1 plus sign-extended immediate
    //   MUL   low 32 bits of the product
    typedef enum logic [2:0] {
        ADD  = 3'd0,
        SUB  = 3'd1,
        AND  = 3'd2,
        XOR  = 3'd3,
        SLT  = 3'd4,
        ADDI = 3'd5,
        MUL  = 3'd6
    } op_t;

endpackage

/* logic/core_if.sv */
/*
 * Issue and writeback handshakes between the control, the units and writeback.
 * new_request is only raised while ready is high. A result stays stable until ack.
 */
`timescale 1ns/1ns

//////////////////////////////
// Unit issue
interface unit_issue_if import core_pkg::*; ();
    logic new_request;
    logic ready;
    op_t op;
    data_t a;
    data_t b;
    reg_addr_t rd;

    modport issue (
        output new_request, op, a, b, rd,
        input ready
    );

    modport unit (
        input new_request, op, a, b, rd,
        output ready
    );
endinterface

//////////////////////////////
// Unit writeback
interface unit_wb_if import core_pkg::*; ();
    logic done;
    logic ack;
    reg_addr_t rd;
    data_t data;

    modport unit (
        output done, rd, data,
        input ack
    );

    modport writeback (
        input done, rd, data,
        output ack
    );
endinterface

/* logic/register_file.sv */
/*
 * Two combinational read ports, one write port.
 * Writes to register zero are dropped, so it always reads zero.
 */
`timescale 1ns/1ns

module register_file import core_pkg::*; (
    input logic clk,
    input logic reset,

    input reg_addr_t rs1_addr,
    input reg_addr_t rs2_addr,
    output data_t rs1_data,
    output data_t rs2_data,

    input logic write_en,
    input reg_addr_t write_rd,
    input data_t write_data
);

    data_t regs [NUM_REGS];

    //////////////////////////////
    // Write port
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && write_rd != '0) begin
            regs[write_rd] <= write_data;
        end
    end

    // Reads see the old value during a same-cycle write
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

/* logic/alu_unit.sv */
/*
 * Single-cycle ALU. The result is held until writeback acks it.
 * A new request can be taken in the same cycle as that ack.
 */
`timescale 1ns/1ns

module alu_unit import core_pkg::*; (
    input logic clk,
    input logic reset,
    unit_issue_if.unit issue,
    unit_wb_if.unit wb
);

    logic result_valid;
    reg_addr_t result_rd;
    data_t result;
    data_t alu_out;

    //////////////////////////////
    // Operation
    always_comb begin
        case (issue.op)
            ADD, ADDI: alu_out = issue.a + issue.b;
            SUB: alu_out = issue.a - issue.b;
            AND: alu_out = issue.a & issue.b;
            XOR: alu_out = issue.a ^ issue.b;
            SLT: alu_out = {31'b0, $signed(issue.a) < $signed(issue.b)};
            default: alu_out = '0;
        endcase
    end

    // Free when empty or when the held result leaves this cycle
    assign issue.ready = !result_valid || wb.ack;

    //////////////////////////////
    // Result register
    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else if (issue.new_request) begin
            result_valid <= 1'b1;
        end else if (wb.ack) begin
            result_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.new_request) begin
            result <= alu_out;
            result_rd <= issue.rd;
        end
    end

    assign wb.done = result_valid;
    assign wb.rd = result_rd;
    assign wb.data = result;

endmodule

/* logic/mul_unit.sv */
/*
 * Pipelined multiplier, low 32 bits of the product.
 * Fixed latency of MUL_STAGES cycles to done. It cannot stall, so writeback
 * must ack done in the same cycle.
 */
`timescale 1ns/1ns

module mul_unit import core_pkg::*; #(
    parameter int MUL_STAGES = 3
) (
    input logic clk,
    input logic reset,
    unit_issue_if.unit issue,
    unit_wb_if.unit wb
);

    logic [MUL_STAGES-1:0] stage_valid;
    reg_addr_t stage_rd [MUL_STAGES];
    data_t stage_prod [MUL_STAGES];
    data_t product;

    assign product = issue.a * issue.b;
    assign issue.ready = 1'b1;

    //////////////////////////////
    // Pipeline
    // Product formed into stage 0, then only carried along
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else begin
            stage_valid[0] <= issue.new_request;
            for (int i = 1; i < MUL_STAGES; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        stage_rd[0] <= issue.rd;
        stage_prod[0] <= product;
        for (int i = 1; i < MUL_STAGES; i++) begin
            stage_rd[i] <= stage_rd[i-1];
            stage_prod[i] <= stage_prod[i-1];
        end
    end

    assign wb.done = stage_valid[MUL_STAGES-1];
    assign wb.rd = stage_rd[MUL_STAGES-1];
    assign wb.data = stage_prod[MUL_STAGES-1];

    // The last stage is overwritten next cycle
    done_acked : assert property (
        @(posedge clk) disable iff (reset)
        wb.done |-> wb.ack
    ) else $error("Multiplier result dropped without ack");

endmodule

/* logic/writeback.sv */
/*
 * Fixed-priority merge of unit results onto one commit port.
 * The multiplier always wins. Commit outputs are registered, one cycle after ack.
 * Results for register zero are acked but never committed.
 */
`timescale 1ns/1ns

module writeback import core_pkg::*; (
    input logic clk,
    input logic reset,

    unit_wb_if.writeback alu_wb,
    unit_wb_if.writeback mul_wb,

    output logic commit_valid,
    output reg_addr_t commit_rd,
    output data_t commit_data
);

    //////////////////////////////
    // Grant
    assign mul_wb.ack = mul_wb.done;
    assign alu_wb.ack = alu_wb.done && !mul_wb.done;

    //////////////////////////////
    // Commit register
    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
        end else if (mul_wb.done) begin
            commit_valid <= (mul_wb.rd != '0);
        end else begin
            commit_valid <= alu_wb.done && (alu_wb.rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        commit_rd <= mul_wb.done ? mul_wb.rd : alu_wb.rd;
        commit_data <= mul_wb.done ? mul_wb.data : alu_wb.data;
    end

    // A waiting ALU result must not change before its ack
    alu_result_held : assert property (
        @(posedge clk) disable iff (reset)
        (alu_wb.done && !alu_wb.ack) |=>
            (alu_wb.done && $stable(alu_wb.rd) && $stable(alu_wb.data))
    ) else $error("ALU result changed before it was acked");

endmodule

/* logic/issue_control.sv */
/*
 * Instruction acceptance, register scoreboard and unit issue.
 * RAW and WAW hazards stall at the instruction port. There is no forwarding,
 * so a dependent instruction issues the cycle after the producer commits.
 */
`timescale 1ns/1ns

module issue_control import core_pkg::*; (
    input logic clk,
    input logic reset,

    input logic instr_valid,
    input op_t instr_op,
    input reg_addr_t instr_rd,
    input reg_addr_t instr_rs1,
    input reg_addr_t instr_rs2,
    input imm_t instr_imm,
    output logic instr_ready,

    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    input data_t rs1_data,
    input data_t rs2_data,

    input logic commit_valid,
    input reg_addr_t commit_rd,

    unit_issue_if.issue alu_issue,
    unit_issue_if.issue mul_issue
);

    logic [NUM_REGS-1:0] pending;
    logic is_mul;
    logic uses_rs2;
    logic rs1_busy;
    logic rs2_busy;
    logic rd_busy;
    logic unit_ready;
    logic accept;
    data_t imm_ext;
    data_t operand_b;

    //////////////////////////////
    // Decode
    assign is_mul = (instr_op == MUL);
    assign uses_rs2 = (instr_op != ADDI);
    assign imm_ext = {{16{instr_imm[15]}}, instr_imm};
    assign operand_b = uses_rs2 ? rs2_data : imm_ext;

    assign rs1_addr = instr_rs1;
    assign rs2_addr = instr_rs2;

    //////////////////////////////
    // Stall conditions
    // Bit zero of the scoreboard is never set
    assign rs1_busy = pending[instr_rs1];
    assign rs2_busy = uses_rs2 && pending[instr_rs2];
    assign rd_busy = (instr_rd != '0) && pending[instr_rd];
    assign unit_ready = is_mul ? mul_issue.ready : alu_issue.ready;

    assign instr_ready = unit_ready && !rs1_busy && !rs2_busy && !rd_busy;
    assign accept = instr_valid && instr_ready;

    //////////////////////////////
    // Scoreboard
    // Set wins over clear, though the rd stall keeps them apart
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            if (commit_valid) begin
                pending[commit_rd] <= 1'b0;
            end
            if (accept && instr_rd != '0) begin
                pending[instr_rd] <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // Unit issue
    assign alu_issue.new_request = accept && !is_mul;
    assign alu_issue.op = instr_op;
    assign alu_issue.a = rs1_data;
    assign alu_issue.b = operand_b;
    assign alu_issue.rd = instr_rd;

    assign mul_issue.new_request = accept && is_mul;
    assign mul_issue.op = instr_op;
    assign mul_issue.a = rs1_data;
    assign mul_issue.b = operand_b;
    assign mul_issue.rd = instr_rd;

    // Every commit retires a register that is still marked pending
    commit_was_pending : assert property (
        @(posedge clk) disable iff (reset)
        commit_valid |-> pending[commit_rd]
    ) else $error("Commit for a register that is not pending");

endmodule

/* logic/exec_core.sv */
/*
 * Integer execution back end with an ALU and a pipelined multiplier.
 * Instruction fields must be held until instr_ready. MUL commits MUL_STAGES+1
 * cycles after acceptance. ALU results may be delayed by multiplier commits.
 */
`timescale 1ns/1ns

module exec_core import core_pkg::*; #(
    parameter int MUL_STAGES = 3
) (
    input logic clk,
    input logic reset,

    input logic instr_valid,
    input op_t instr_op,
    input reg_addr_t instr_rd,
    input reg_addr_t instr_rs1,
    input reg_addr_t instr_rs2,
    input imm_t instr_imm,
    output logic instr_ready,

    output logic commit_valid,
    output reg_addr_t commit_rd,
    output data_t commit_data
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    data_t rs1_data;
    data_t rs2_data;

    unit_issue_if alu_issue ();
    unit_issue_if mul_issue ();
    unit_wb_if alu_wb ();
    unit_wb_if mul_wb ();

    //////////////////////////////
    // Issue and registers
    issue_control issue_control_block (
        .clk (clk),
        .reset (reset),
        .instr_valid (instr_valid),
        .instr_op (instr_op),
        .instr_rd (instr_rd),
        .instr_rs1 (instr_rs1),
        .instr_rs2 (instr_rs2),
        .instr_imm (instr_imm),
        .instr_ready (instr_ready),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .commit_valid (commit_valid),
        .commit_rd (commit_rd),
        .alu_issue (alu_issue),
        .mul_issue (mul_issue)
    );

    register_file register_file_block (
        .clk (clk),
        .reset (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .write_en (commit_valid),
        .write_rd (commit_rd),
        .write_data (commit_data)
    );

    //////////////////////////////
    // Execution units
    alu_unit alu_unit_block (
        .clk (clk),
        .reset (reset),
        .issue (alu_issue),
        .wb (alu_wb)
    );

    mul_unit #(.MUL_STAGES(MUL_STAGES)) mul_unit_block (
        .clk (clk),
        .reset (reset),
        .issue (mul_issue),
        .wb (mul_wb)
    );

    //////////////////////////////
    // Writeback
    writeback writeback_block (
        .clk (clk),
        .reset (reset),
        .alu_wb (alu_wb),
        .mul_wb (mul_wb),
        .commit_valid (commit_valid),
        .commit_rd (commit_rd),
        .commit_data (commit_data)
    );

endmodule

/* testbench/tb_clock.sv */
/*
 * Free-running testbench clock with a synchronous reset pulse.
 * Reset is released on a rising edge after RESET_CYCLES edges.
 */
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset <= 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* testbench/exec_core_tb.sv */
/*
 * Random instruction stream against a register model of the core.
 * Inputs change only on rising edges, outputs are sampled on rising edges.
 * A commit for r0 or for a register with no result in flight is an error.
 */
`timescale 1ns/1ns

module exec_core_tb import core_pkg::*; ();

    localparam int MUL_STAGES = 3;
    localparam int MUL_LATENCY = MUL_STAGES + 1;
    localparam int NUM_INSTR = 400;
    localparam int NUM_LOADS = 8;
    localparam int REG_RANGE = 9;
    localparam int DRAIN_QUIET = 10;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 8 + 200;

    logic clk;
    logic reset;
    logic instr_valid;
    op_t instr_op;
    reg_addr_t instr_rd;
    reg_addr_t instr_rs1;
    reg_addr_t instr_rs2;
    imm_t instr_imm;
    logic instr_ready;
    logic commit_valid;
    reg_addr_t commit_rd;
    data_t commit_data;

    integer seed;
    int cycle_count = 0;
    int issued;
    int commits_seen;
    int mul_commits;

    // Model registers and one expectation per destination
    data_t model_regs [NUM_REGS];
    data_t exp_data [NUM_REGS];
    logic exp_valid [NUM_REGS];
    logic exp_is_mul [NUM_REGS];
    int exp_cycle [NUM_REGS];

    tb_clock #(.PERIOD(8), .RESET_CYCLES(10)) clock_gen (
        .clk (clk),
        .reset (reset)
    );

    exec_core #(.MUL_STAGES(MUL_STAGES)) dut (
        .clk (clk),
        .reset (reset),
        .instr_valid (instr_valid),
        .instr_op (instr_op),
        .instr_rd (instr_rd),
        .instr_rs1 (instr_rs1),
        .instr_rs2 (instr_rs2),
        .instr_imm (instr_imm),
        .instr_ready (instr_ready),
        .commit_valid (commit_valid),
        .commit_rd (commit_rd),
        .commit_data (commit_data)
    );

    //////////////////////////////
    // Failure reporting
    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "Stopping at first error");
    endtask

    task automatic report_failure(string reason);
        $display("Error: %s", reason);
        abort_run();
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            abort_run();
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    //////////////////////////////
    // Reference model
    function automatic logic [31:0] random_word();
        return $random(seed);
    endfunction

    function automatic data_t model_result(op_t op, data_t a, data_t b);
        logic [63:0] product;
        data_t result;
        product = 64'(a) * 64'(b);
        case (op)
            ADD, ADDI: result = a + b;
            SUB: result = a - b;
            AND: result = a & b;
            XOR: result = a ^ b;
            SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            MUL: result = product[31:0];
            default: result = '0;
        endcase
        return result;
    endfunction

    function automatic int outstanding_results();
        int count;
        count = 0;
        for (int r = 0; r < NUM_REGS; r++) begin
            if (exp_valid[r]) count++;
        end
        return count;
    endfunction

    //////////////////////////////
    // Stimulus and checking
    // First loads go to r1..r8 from r0
    task automatic present_instruction(int index);
        logic [2:0] op_code;
        if (index < NUM_LOADS) begin
            instr_op <= ADDI;
            instr_rd <= reg_addr_t'(index + 1);
            instr_rs1 <= '0;
            instr_rs2 <= '0;
        end else begin
            op_code = 3'(random_word() % 7);
            instr_op <= op_t'(op_code);
            instr_rd <= reg_addr_t'(random_word() % REG_RANGE);
            instr_rs1 <= reg_addr_t'(random_word() % REG_RANGE);
            instr_rs2 <= reg_addr_t'(random_word() % REG_RANGE);
        end
        instr_imm <= imm_t'(random_word());
        instr_valid <= 1'b1;
    endtask

    // Sources are final at acceptance since RAW hazards stall
    task automatic record_accept();
        data_t a;
        data_t b;
        data_t result;
        a = model_regs[instr_rs1];
        b = (instr_op == ADDI) ? {{16{instr_imm[15]}}, instr_imm} : model_regs[instr_rs2];
        result = model_result(instr_op, a, b);
        if (instr_rd != '0) begin
            if (exp_valid[instr_rd]) begin
                report_failure($sformatf("accepted a write to r%0d while one is in flight",
                                         instr_rd));
            end
            model_regs[instr_rd] = result;
            exp_data[instr_rd] = result;
            exp_valid[instr_rd] = 1'b1;
            exp_is_mul[instr_rd] = (instr_op == MUL);
            exp_cycle[instr_rd] = cycle_count;
        end
    endtask

    // r0 never holds an expectation, so its commits fail here too
    task automatic check_commit();
        reg_addr_t rd;
        if (commit_valid) begin
            rd = commit_rd;
            if (!exp_valid[rd]) begin
                report_failure($sformatf("commit for r%0d that has no pending result", rd));
            end else begin
                check_value($sformatf("data r%0d", rd), exp_data[rd], commit_data);
                if (exp_is_mul[rd]) begin
                    check_value($sformatf("mul latency r%0d", rd),
                                exp_cycle[rd] + MUL_LATENCY, cycle_count);
                    mul_commits++;
                end
                exp_valid[rd] = 1'b0;
                commits_seen++;
            end
        end
    endtask

    initial begin
        instr_valid <= 1'b0;
        instr_op <= ADD;
        instr_rd <= '0;
        instr_rs1 <= '0;
        instr_rs2 <= '0;
        instr_imm <= '0;
        seed = 28;
        issued = 0;
        commits_seen = 0;
        mul_commits = 0;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
            exp_data[r] = '0;
            exp_valid[r] = 1'b0;
            exp_is_mul[r] = 1'b0;
            exp_cycle[r] = 0;
        end

        // Commit port must stay quiet through reset
        @(posedge clk);
        while (reset) begin
            @(posedge clk);
            check_value("commit_valid in reset", 32'd0, 32'(commit_valid));
        end

        present_instruction(0);
        while (issued < NUM_INSTR) begin
            @(posedge clk);
            check_commit();
            if (instr_valid && instr_ready) begin
                record_accept();
                issued++;
                // Occasional bubble between instructions
                if (issued < NUM_INSTR && (random_word() & 32'd7) != 32'd0) begin
                    present_instruction(issued);
                end else begin
                    instr_valid <= 1'b0;
                end
            end else if (!instr_valid) begin
                present_instruction(issued);
            end
        end

        // Drain, then a quiet window to catch late extra commits
        while (outstanding_results() != 0) begin
            @(posedge clk);
            check_commit();
        end
        repeat (DRAIN_QUIET) begin
            @(posedge clk);
            check_commit();
        end

        $display("Checked %0d commits, %0d from the multiplier", commits_seen, mul_commits);
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* files.f */
logic/core_pkg.sv
logic/core_if.sv
logic/register_file.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/writeback.sv
logic/issue_control.sv
logic/exec_core.sv
testbench/tb_clock.sv
testbench/exec_core_tb.sv

/* run.sh */
#!/bin/bash
# Build and run the exec_core testbench with Verilator, judge the run from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f files.f --top-module exec_core_tb \
    -o exec_core_sim || { echo "Build failed"; exit 1; }
./obj_dir/exec_core_sim > sim.log 2>&1
cat sim.log
grep -q "Result: PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
